/* common/nmg_pkg.sv */
// shared types and constants for the management-plane configuration path
// command words from the frame parser, read responses from the executor,
// status counters and the address map of the configuration register bank
// referenced by scoped names from every block that needs them

`default_nettype none

package nmg_pkg;

    // ****************************************
    // request type byte
    // ****************************************
    localparam logic [7:0] NM_TYPE_READ  = 8'h01;   // host reads registers/RAM
    localparam logic [7:0] NM_TYPE_WRITE = 8'h02;   // host writes registers/RAM

    // byte index of the type byte within a frame
    localparam int unsigned NM_TYPE_OFFSET = 15;

    // ****************************************
    // address map
    // ****************************************
    // registers sit at 0 .. REG_COUNT-1 as sized by the top level
    localparam logic [31:0] RAM_BASE = 32'h0000_1000;  // first RAM word

    // ****************************************
    // command and response words
    // ****************************************
    typedef enum logic {
        NM_OP_WRITE = 1'b0,
        NM_OP_READ  = 1'b1
    } nm_op_e;

    // one command of 65 bits
    typedef struct packed {
        nm_op_e      op;
        logic [31:0] addr;
        logic [31:0] data;     // don't care on reads
    } nm_cmd_t;

    // one read response of 64 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } nm_rd_resp_t;

    // status seen at the top level
    typedef struct packed {
        logic [7:0] frame_cnt;  // frames with a valid type byte
        logic [7:0] drop_cnt;   // commands lost to a full FIFO
    } nm_status_t;

endpackage

`default_nettype wire

/* network_management/nm_frame_parse.sv */
// management frame parser
// walks the 9-bit byte stream, bit 8 flags first and last byte of a frame,
// pulls out the MACs, the request type, the word count and the base address,
// then turns each following 4-byte word into one command with a 1-cycle valid
// a strobe gap anywhere inside a frame drops back to idle

`default_nettype none

module nm_frame_parse (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire  [8:0]              i_data,
    input  wire                     i_data_wr,
    output logic [47:0]             o_dmac,
    output logic [47:0]             o_smac,
    output logic                    o_frame_pulse,
    output nmg_pkg::nm_cmd_t        o_cmd,
    output logic                    o_cmd_valid,
    output logic [7:0]              o_frame_cnt
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DMAC,
        S_SMAC,
        S_TYPE,
        S_COUNT,
        S_ADDR,
        S_DATA,
        S_DISC
    } state_e;

    state_e      state;
    logic [3:0]  byte_cnt;      // header byte index, then byte within a field
    logic [15:0] rem_cnt;       // command words still to come
    logic        first_word;    // next word uses the base address as is
    logic        type_hit;      // current byte is the type byte
    logic        type_ok;

    assign type_hit = (state == S_TYPE) && (byte_cnt == 4'(nmg_pkg::NM_TYPE_OFFSET));
    assign type_ok  = (i_data[7:0] == nmg_pkg::NM_TYPE_READ) ||
                      (i_data[7:0] == nmg_pkg::NM_TYPE_WRITE);

    // ****************************************
    // control FSM
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= S_IDLE;
            byte_cnt      <= 4'd0;
            rem_cnt       <= 16'd0;
            first_word    <= 1'b0;
            o_frame_pulse <= 1'b0;
            o_cmd_valid   <= 1'b0;
            o_frame_cnt   <= 8'd0;
        end else begin
            o_cmd_valid <= 1'b0;
            if (state != S_IDLE && !i_data_wr) begin
                state         <= S_IDLE;    // strobe gap abandons the frame
                o_frame_pulse <= 1'b0;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (i_data_wr && i_data[8]) begin
                            byte_cnt      <= 4'd1;
                            o_frame_pulse <= 1'b1;
                            state         <= S_DMAC;
                        end
                    end
                    S_DMAC: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd5)
                            state <= S_SMAC;
                    end
                    S_SMAC: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd11)
                            state <= S_TYPE;
                    end
                    S_TYPE: begin
                        byte_cnt <= byte_cnt + 4'd1;     // skips bytes 12..14
                        if (type_hit) begin
                            byte_cnt      <= 4'd0;
                            o_frame_pulse <= 1'b0;
                            if (type_ok) begin
                                o_frame_cnt <= o_frame_cnt + 8'd1;
                                state       <= S_COUNT;
                            end else begin
                                state <= S_IDLE;
                            end
                        end
                    end
                    S_COUNT: begin
                        rem_cnt  <= {rem_cnt[7:0], i_data[7:0]};   // MSB first
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd1) begin
                            byte_cnt <= 4'd0;
                            state    <= S_ADDR;
                        end
                    end
                    S_ADDR: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd3) begin
                            byte_cnt   <= 4'd0;
                            first_word <= 1'b1;
                            if (rem_cnt != 16'd0)
                                state <= S_DATA;
                            else
                                state <= i_data[8] ? S_IDLE : S_DISC;  // empty frame
                        end
                    end
                    S_DATA: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd3) begin
                            byte_cnt    <= 4'd0;
                            first_word  <= 1'b0;
                            o_cmd_valid <= 1'b1;
                            if (rem_cnt == 16'd1)
                                state <= i_data[8] ? S_IDLE : S_DISC;
                            else
                                rem_cnt <= rem_cnt - 16'd1;
                        end
                    end
                    S_DISC: begin
                        if (i_data[8])
                            state <= S_IDLE;                   // end flag found
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // ****************************************
    // header fields and command payload
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (i_data_wr) begin
            if ((state == S_IDLE && i_data[8]) || state == S_DMAC)
                o_dmac <= {o_dmac[39:0], i_data[7:0]};
            if (state == S_SMAC)
                o_smac <= {o_smac[39:0], i_data[7:0]};
            if (type_hit)
                o_cmd.op <= (i_data[7:0] == nmg_pkg::NM_TYPE_READ) ?
                            nmg_pkg::NM_OP_READ : nmg_pkg::NM_OP_WRITE;
            if (state == S_ADDR)
                o_cmd.addr <= {o_cmd.addr[23:0], i_data[7:0]};
            if (state == S_DATA) begin
                o_cmd.data <= {o_cmd.data[23:0], i_data[7:0]};
                if (byte_cnt == 4'd3 && !first_word)
                    o_cmd.addr <= o_cmd.addr + 32'd1;     // later words step on
            end
        end
    end

endmodule

`default_nettype wire

/* network_management/nm_cmd_fifo.sv */
// command queue between the parser and the executor
// the parser side cannot stall, so a push into a full queue is dropped
// and counted; the executor side is a plain valid/ready handshake

`default_nettype none

module nm_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire  nmg_pkg::nm_cmd_t  i_cmd,
    input  wire                     i_cmd_valid,
    input  wire                     i_cmd_ready,
    output nmg_pkg::nm_cmd_t        o_cmd,
    output logic                    o_cmd_valid,
    output logic [7:0]              o_drop_cnt
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    nmg_pkg::nm_cmd_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full        = (count == CNT_W'(FIFO_DEPTH));
    assign pop         = o_cmd_valid && i_cmd_ready;
    assign push        = i_cmd_valid && (!full || pop);   // slot freed this cycle
    assign o_cmd_valid = (count != '0);
    assign o_cmd       = mem[rd_ptr];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_drop_cnt <= 8'd0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (i_cmd_valid && !push && o_drop_cnt != 8'hff)
                o_drop_cnt <= o_drop_cnt + 8'd1;             // saturates
        end
    end

    always_ff @(posedge i_clk) begin
        if (push)
            mem[wr_ptr] <= i_cmd;
    end

endmodule

`default_nettype wire

/* network_management/nm_cmd_exec.sv */
// command executor
// takes one command per cycle from the queue and drives the register bank
// port in the same cycle; writes finish there, reads hold off the queue for
// one capture cycle and then present an address/data response for one cycle
// the response port has no back-pressure

`default_nettype none

module nm_cmd_exec (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire  nmg_pkg::nm_cmd_t  i_cmd,
    input  wire                     i_cmd_valid,
    input  wire  [31:0]             i_bank_rdata,
    output logic                    o_cmd_ready,
    output logic                    o_bank_en,
    output logic                    o_bank_we,
    output logic [31:0]             o_bank_addr,
    output logic [31:0]             o_bank_wdata,
    output nmg_pkg::nm_rd_resp_t    o_rd_resp,
    output logic                    o_rd_resp_valid
);

    typedef enum logic {
        S_ISSUE,
        S_CAPTURE
    } state_e;

    state_e      state;
    logic        accept;
    logic        is_read;
    logic [31:0] rd_addr;       // address of the read in flight

    // ****************************************
    // issue side
    // ****************************************
    assign o_cmd_ready = (state == S_ISSUE);
    assign accept      = i_cmd_valid && o_cmd_ready;
    assign is_read     = (i_cmd.op == nmg_pkg::NM_OP_READ);

    // bank request follows the queue head directly
    assign o_bank_en    = accept;
    assign o_bank_we    = accept && !is_read;
    assign o_bank_addr  = i_cmd.addr;
    assign o_bank_wdata = i_cmd.data;

    // ****************************************
    // sequencer
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state           <= S_ISSUE;
            o_rd_resp_valid <= 1'b0;
        end else begin
            o_rd_resp_valid <= 1'b0;
            case (state)
                S_ISSUE: begin
                    if (accept && is_read)
                        state <= S_CAPTURE;     // bank data arrives next cycle
                end
                S_CAPTURE: begin
                    o_rd_resp_valid <= 1'b1;
                    state           <= S_ISSUE;
                end
                default: state <= S_ISSUE;
            endcase
        end
    end

    // response payload
    always_ff @(posedge i_clk) begin
        if (accept && is_read)
            rd_addr <= i_cmd.addr;
        if (state == S_CAPTURE) begin
            o_rd_resp.addr <= rd_addr;
            o_rd_resp.data <= i_bank_rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_reg_bank.sv */
// configuration register bank
// control registers at 0 .. REG_COUNT-1 and a RAM window starting at
// RAM_BASE, behind one access port; read data is registered, so it shows
// one cycle after an enable with the write enable low
// writes to unmapped addresses are lost, reads there return zero

`default_nettype none

module cfg_reg_bank #(
    parameter int REG_COUNT = 16,
    parameter int RAM_DEPTH = 256
) (
    input  wire          i_clk,
    input  wire          i_rst_n,
    input  wire          i_en,
    input  wire          i_we,
    input  wire  [31:0]  i_addr,
    input  wire  [31:0]  i_wdata,
    output logic [31:0]  o_rdata
);

    localparam int REG_AW = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;
    localparam int RAM_AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    logic [31:0]       regs [REG_COUNT];
    logic [31:0]       ram  [RAM_DEPTH];
    logic              reg_hit;
    logic              ram_hit;
    logic [31:0]       ram_off;
    logic [REG_AW-1:0] reg_idx;
    logic [RAM_AW-1:0] ram_idx;

    // ****************************************
    // address decode
    // ****************************************
    assign reg_hit = (i_addr < 32'(REG_COUNT));
    assign ram_hit = (i_addr >= nmg_pkg::RAM_BASE) &&
                     (i_addr < nmg_pkg::RAM_BASE + 32'(RAM_DEPTH));
    assign ram_off = i_addr - nmg_pkg::RAM_BASE;
    assign reg_idx = i_addr[REG_AW-1:0];
    assign ram_idx = ram_off[RAM_AW-1:0];

    // control registers cleared on reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= 32'd0;
        end else if (i_en && i_we && reg_hit) begin
            regs[reg_idx] <= i_wdata;
        end
    end

    // RAM write and registered read port
    always_ff @(posedge i_clk) begin
        if (i_en && i_we && ram_hit)
            ram[ram_idx] <= i_wdata;
        if (i_en && !i_we) begin
            if (reg_hit)
                o_rdata <= regs[reg_idx];
            else if (ram_hit)
                o_rdata <= ram[ram_idx];
            else
                o_rdata <= 32'd0;           // unmapped
        end
    end

endmodule

`default_nettype wire

/* verilog/nm_subsystem_top.sv */
// management-plane configuration subsystem
// byte stream in, parser -> command FIFO -> executor -> register bank,
// read responses and status counters out; sizes are set here and passed down

`default_nettype none

module nm_subsystem_top #(
    parameter int REG_COUNT  = 16,
    parameter int RAM_DEPTH  = 256,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire  [8:0]              i_data,
    input  wire                     i_data_wr,
    output logic [47:0]             o_dmac,
    output logic [47:0]             o_smac,
    output logic                    o_frame_pulse,
    output nmg_pkg::nm_rd_resp_t    o_rd_resp,
    output logic                    o_rd_resp_valid,
    output nmg_pkg::nm_status_t     o_status
);

    nmg_pkg::nm_cmd_t parse_cmd;
    logic             parse_cmd_valid;
    nmg_pkg::nm_cmd_t fifo_cmd;
    logic             fifo_cmd_valid;
    logic             exec_ready;
    logic             bank_en;
    logic             bank_we;
    logic [31:0]      bank_addr;
    logic [31:0]      bank_wdata;
    logic [31:0]      bank_rdata;
    logic [7:0]       frame_cnt;
    logic [7:0]       drop_cnt;

    assign o_status.frame_cnt = frame_cnt;
    assign o_status.drop_cnt  = drop_cnt;

    nm_frame_parse parse_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_data        (i_data),
        .i_data_wr     (i_data_wr),
        .o_dmac        (o_dmac),
        .o_smac        (o_smac),
        .o_frame_pulse (o_frame_pulse),
        .o_cmd         (parse_cmd),
        .o_cmd_valid   (parse_cmd_valid),
        .o_frame_cnt   (frame_cnt)
    );

    nm_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (parse_cmd),
        .i_cmd_valid (parse_cmd_valid),
        .i_cmd_ready (exec_ready),
        .o_cmd       (fifo_cmd),
        .o_cmd_valid (fifo_cmd_valid),
        .o_drop_cnt  (drop_cnt)
    );

    nm_cmd_exec exec_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_cmd           (fifo_cmd),
        .i_cmd_valid     (fifo_cmd_valid),
        .i_bank_rdata    (bank_rdata),
        .o_cmd_ready     (exec_ready),
        .o_bank_en       (bank_en),
        .o_bank_we       (bank_we),
        .o_bank_addr     (bank_addr),
        .o_bank_wdata    (bank_wdata),
        .o_rd_resp       (o_rd_resp),
        .o_rd_resp_valid (o_rd_resp_valid)
    );

    cfg_reg_bank #(
        .REG_COUNT (REG_COUNT),
        .RAM_DEPTH (RAM_DEPTH)
    ) bank_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_en    (bank_en),
        .i_we    (bank_we),
        .i_addr  (bank_addr),
        .i_wdata (bank_wdata),
        .o_rdata (bank_rdata)
    );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
// testbench clock and reset source
// 100 ns clock, active-low reset held for three cycles and then
// released on a falling edge, away from the DUT's sampling edge

`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_nm_subsystem.sv */
// directed testbench for the management-plane configuration subsystem
// builds management frames byte by byte on the falling clock edge, keeps a
// model of the registers and the RAM, and checks read responses, MACs and
// the status counters; a monitor gathers responses for in-order matching

`default_nettype none

module tb_nm_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REG_COUNT    = 16;
    localparam int RAM_DEPTH    = 256;
    localparam int FIFO_DEPTH   = 4;
    localparam int RESP_TIMEOUT = 200;     // cycles
    localparam int RST_TIMEOUT  = 20;
    localparam int WORD_START   = 22;      // first byte of the command words
    localparam logic [47:0] HDR_DMAC = 48'h02_11_22_33_44_55;
    localparam logic [47:0] HDR_SMAC = 48'h02_a0_b1_c2_d3_e4;

    logic                  clk;
    logic                  rst_n;
    logic [8:0]            data;
    logic                  data_wr;
    logic [47:0]           dmac;
    logic [47:0]           smac;
    logic                  frame_pulse;
    nmg_pkg::nm_rd_resp_t  rd_resp;
    logic                  rd_resp_valid;
    nmg_pkg::nm_status_t   status;

    nmg_pkg::nm_rd_resp_t  got_resp [$];   // filled by the monitor only
    nmg_pkg::nm_rd_resp_t  exp_resp [$];
    int                    got_idx;
    int                    pulse_cycles = 0;
    logic [31:0]           frame_words [$];
    logic [8:0]            frame_bytes [$];
    logic [31:0]           sb_regs [REG_COUNT];
    logic [31:0]           sb_ram  [RAM_DEPTH];
    logic [31:0]           lfsr;
    logic [7:0]            exp_frames;
    int                    value_errs;
    int                    other_errs;

    tb_clk_gen clk_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    nm_subsystem_top #(
        .REG_COUNT  (REG_COUNT),
        .RAM_DEPTH  (RAM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_data          (data),
        .i_data_wr       (data_wr),
        .o_dmac          (dmac),
        .o_smac          (smac),
        .o_frame_pulse   (frame_pulse),
        .o_rd_resp       (rd_resp),
        .o_rd_resp_valid (rd_resp_valid),
        .o_status        (status)
    );

    // responses and frame pulse sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n && rd_resp_valid)
            got_resp.push_back(rd_resp);
        if (frame_pulse)
            pulse_cycles++;
    end

    // ****************************************
    // stimulus helpers and reference model
    // ****************************************
    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_word();
        logic        fb;
        logic [31:0] w;
        w = 32'd0;
        for (int b = 0; b < 32; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    task automatic load_random_words(input int n);
        frame_words = {};
        for (int k = 0; k < n; k++)
            frame_words.push_back(rand_word());
    endtask

    task automatic push_be(input logic [47:0] value, input int nbytes);
        for (int i = 0; i < nbytes; i++)
            frame_bytes.push_back({1'b0, value[8*(nbytes-1-i) +: 8]});   // MSB first
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (addr < 32'(REG_COUNT))
            return sb_regs[int'(addr)];
        if (addr >= nmg_pkg::RAM_BASE && addr < nmg_pkg::RAM_BASE + 32'(RAM_DEPTH))
            return sb_ram[int'(addr - nmg_pkg::RAM_BASE)];
        return 32'd0;                            // unmapped
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata);
        if (addr < 32'(REG_COUNT))
            sb_regs[int'(addr)] = wdata;
        else if (addr >= nmg_pkg::RAM_BASE && addr < nmg_pkg::RAM_BASE + 32'(RAM_DEPTH))
            sb_ram[int'(addr - nmg_pkg::RAM_BASE)] = wdata;
    endtask

    // one frame from frame_words with a strobe gap before byte gap_at
    // negative gap_at sends the frame without a gap
    task automatic send_frame(input logic [7:0] typ, input logic [15:0] count,
                              input logic [31:0] base, input bit no_end,
                              input int gap_at);
        bit                   typ_ok;
        nmg_pkg::nm_rd_resp_t resp;
        frame_bytes = {};
        push_be(HDR_DMAC, 6);
        push_be(HDR_SMAC, 6);
        push_be(48'h88_b5_00, 3);                // bytes 12..14 unused
        push_be(48'(typ), 1);
        push_be(48'(count), 2);
        push_be(48'(base), 4);
        for (int k = 0; k < int'(count); k++)
            push_be(48'(frame_words[k]), 4);
        if (no_end)
            push_be(48'h00_a5_5a, 3);            // trailing junk to be discarded
        frame_bytes[0] = frame_bytes[0] | 9'h100;
        frame_bytes[frame_bytes.size()-1] = frame_bytes[frame_bytes.size()-1] | 9'h100;

        // expected effect of the words fully received before any gap
        typ_ok = (typ == nmg_pkg::NM_TYPE_READ) || (typ == nmg_pkg::NM_TYPE_WRITE);
        if (typ_ok && (gap_at < 0 || gap_at > int'(nmg_pkg::NM_TYPE_OFFSET)))
            exp_frames = exp_frames + 8'd1;
        for (int k = 0; k < int'(count); k++) begin
            if (typ_ok && (gap_at < 0 || gap_at > WORD_START + 4 * k + 3)) begin
                if (typ == nmg_pkg::NM_TYPE_WRITE) begin
                    model_write(base + 32'(k), frame_words[k]);
                end else begin
                    resp.addr = base + 32'(k);
                    resp.data = model_read(base + 32'(k));
                    exp_resp.push_back(resp);
                end
            end
        end

        for (int i = 0; i < frame_bytes.size(); i++) begin
            @(negedge clk);
            if (i == gap_at) begin
                data_wr = 1'b0;                  // parser drops the frame here
                @(negedge clk);
            end
            data    = frame_bytes[i];
            data_wr = 1'b1;
        end
        @(negedge clk);
        data_wr = 1'b0;
        data    = 9'd0;
        repeat (2) @(negedge clk);
    endtask

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_rd_resp(input nmg_pkg::nm_rd_resp_t got,
                                 input nmg_pkg::nm_rd_resp_t exp);
        if (got !== exp) begin
            $display("FAIL o_rd_resp: got addr %h data %h, expected addr %h data %h",
                     got.addr, got.data, exp.addr, exp.data);
            value_errs++;
        end
    endtask

    task automatic check_status(input nmg_pkg::nm_status_t got,
                                input nmg_pkg::nm_status_t exp);
        if (got !== exp) begin
            $display("FAIL o_status: got frame_cnt %h drop_cnt %h, expected %h %h",
                     got.frame_cnt, got.drop_cnt, exp.frame_cnt, exp.drop_cnt);
            value_errs++;
        end
    endtask

    task automatic check_mac(input string name, input logic [47:0] got,
                             input logic [47:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // ****************************************
    // response handling
    // ****************************************
    task automatic await_responses(input string what);
        int n;
        int want;
        want = got_idx + exp_resp.size();
        n    = 0;
        while (got_resp.size() < want && n < RESP_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (got_resp.size() < want) begin
            $display("%s: timed out after %0d cycles, only %0d of %0d read responses came",
                     what, RESP_TIMEOUT, got_resp.size() - got_idx, exp_resp.size());
            other_errs++;
        end
        while (exp_resp.size() > 0) begin
            if (got_idx < got_resp.size()) begin
                check_rd_resp(got_resp[got_idx], exp_resp.pop_front());
                got_idx++;
            end else begin
                void'(exp_resp.pop_front());
            end
        end
    endtask

    // no read response may show up within the window
    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) @(posedge clk);
        if (got_resp.size() != got_idx) begin
            $display("%s: %0d read responses appeared where none were expected",
                     what, got_resp.size() - got_idx);
            other_errs++;
            got_idx = got_resp.size();
        end
    endtask

    task automatic run_read(input logic [15:0] count, input logic [31:0] base,
                            input string what);
        frame_words = {};
        for (int k = 0; k < int'(count); k++)
            frame_words.push_back({16'hffff, 16'(k)});     // ignored on reads
        send_frame(nmg_pkg::NM_TYPE_READ, count, base, 1'b0, -1);
        await_responses(what);
    endtask

    // ****************************************
    // directed tests
    // ****************************************
    task automatic reset_and_first_frame();
        int pulse_base;
        check_flag("o_rd_resp_valid", rd_resp_valid, 1'b0);
        check_flag("o_frame_pulse", frame_pulse, 1'b0);
        check_status(status, 16'h0000);
        pulse_base = pulse_cycles;
        load_random_words(1);
        send_frame(nmg_pkg::NM_TYPE_WRITE, 16'd1, 32'd1, 1'b0, -1);
        check_mac("o_dmac", dmac, HDR_DMAC);
        check_mac("o_smac", smac, HDR_SMAC);
        if (pulse_cycles == pulse_base) begin
            $display("o_frame_pulse never went high during the first frame");
            other_errs++;
        end
    endtask

    task automatic reg_write_read_back();
        load_random_words(4);
        send_frame(nmg_pkg::NM_TYPE_WRITE, 16'd4, 32'd2, 1'b0, -1);
        run_read(16'd4, 32'd2, "register read-back");
    endtask

    task automatic ram_write_read_back();
        load_random_words(8);
        send_frame(nmg_pkg::NM_TYPE_WRITE, 16'd8, nmg_pkg::RAM_BASE + 32'h10, 1'b0, -1);
        run_read(16'd8, nmg_pkg::RAM_BASE + 32'h10, "RAM read-back");
        run_read(16'd1, 32'h800, "unmapped read");
    endtask

    task automatic bad_type_ignored();
        nmg_pkg::nm_status_t exp;
        load_random_words(2);
        send_frame(8'h03, 16'd2, 32'd2, 1'b0, -1);
        expect_quiet(20, "bad type frame");
        run_read(16'd6, 32'd0, "read after bad type");
        exp.frame_cnt = exp_frames;
        exp.drop_cnt  = 8'd0;
        check_status(status, exp);
    endtask

    task automatic abandoned_frames();
        load_random_words(4);
        send_frame(nmg_pkg::NM_TYPE_WRITE, 16'd4, 32'd8, 1'b0, WORD_START + 10);  // inside word 2
        run_read(16'd4, 32'd8, "read after strobe gap");
        load_random_words(2);
        send_frame(nmg_pkg::NM_TYPE_WRITE, 16'd2, 32'd12, 1'b1, -1);
        check_mac("o_dmac", dmac, HDR_DMAC);    // flagged junk byte opens no frame
        run_read(16'd2, 32'd12, "read after missing end flag");
    endtask

    task automatic status_counters();
        nmg_pkg::nm_status_t exp;
        exp.frame_cnt = exp_frames;
        exp.drop_cnt  = 8'd0;
        check_status(status, exp);
        expect_quiet(10, "end of run");
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        int n;
        data         = 9'd0;
        data_wr      = 1'b0;
        lfsr         = 32'h1146;
        exp_frames   = 8'd0;
        got_idx      = 0;
        value_errs   = 0;
        other_errs   = 0;
        for (int i = 0; i < REG_COUNT; i++)
            sb_regs[i] = 32'd0;                 // registers clear on reset

        n = 0;
        while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was still asserted after %0d cycles", RST_TIMEOUT);
            other_errs++;
        end
        @(negedge clk);

        reset_and_first_frame();
        reg_write_read_back();
        ram_write_read_back();
        bad_type_ignored();
        abandoned_frames();
        status_counters();
        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
common/nmg_pkg.sv
network_management/nm_frame_parse.sv
network_management/nm_cmd_fifo.sv
network_management/nm_cmd_exec.sv
verilog/cfg_reg_bank.sv
verilog/nm_subsystem_top.sv
test/tb_clk_gen.sv
test/tb_nm_subsystem.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_nm_subsystem
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully
FAIL_MSG  := Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; \
	else echo "test passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
